/* verif/pmp_input.txt */
# fields in hex, last field is the expected mem_fault
# E en exp | S id sp exp | C csr_addr op(1 wr,2 set,3 clr) wdata exp | A id opcode addr exp
E 1 0
A 01 03 0000 0
A 01 23 fff0 0
A 80 03 1234 0
S 01 1000 0
A 01 03 0fff 1
A 01 03 1000 0
C 400 1 02ff0200 0
C 480 1 00000001 0
A 01 03 0250 0
A 01 23 0250 1
A 01 03 0300 1
A 01 03 01ff 1
C 401 1 03ff0280 0
C 480 2 00000300 0
A 01 23 0290 1
A 01 23 0390 0
C 480 2 00000002 0
A 01 23 0290 0
C 480 3 00000001 0
A 01 03 0290 1
A 01 03 0390 0
C 480 2 00000080 0
C 400 1 00000000 0
A 01 23 0250 0
C 480 1 00000303 0
A 01 03 0250 1
C 480 3 000000ff 0
A 01 23 0250 0
A 02 03 0250 0
S 02 0800 0
A 02 03 0250 1
E 0 0
A 01 03 0fff 0
A 00 03 2000 0
E 1 0
A 01 13 0fff 0
A 01 03 0fff 1
A 00 03 2000 1
A 03 23 2000 1
A 03 33 2000 0

/* filelist.f */
logic/pmp_access_pkg.sv
logic/pmp_csr_pkg.sv
logic/pmp_task_tracker.sv
logic/pmp_csr_file.sv
logic/pmp_region_check.sv
logic/pmp_fault_resolve.sv
logic/pmp.sv
verif/pmp_sva.sv
verif/pmp_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module pmp_tb -f filelist.f -o pmp_sim
	./obj_dir/pmp_sim | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/pmp_tb.sv */
module pmp_tb
    import pmp_access_pkg::*;
    import pmp_csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    localparam int OPEN_TRIES   = 4;
    localparam int MAX_LINES    = 1000;  // upper limit on lines read

    logic         clk;
    logic         reset;
    logic         enable;
    mem_addr_t    addr;
    opcode_t      op;
    task_onehot_t id;
    logic         ctx_save;
    mem_addr_t    sp;
    logic         csr_enable;
    csr_addr_t    csr_addr;
    csr_op_e      csr_op;
    csr_word_t    csr_wdata;
    logic         mem_fault;

    int errors;
    int checks;

    pmp DUT (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .addr       (addr),
        .op         (op),
        .id         (id),
        .ctx_save   (ctx_save),
        .sp         (sp),
        .csr_enable (csr_enable),
        .csr_addr   (csr_addr),
        .csr_op     (csr_op),
        .csr_wdata  (csr_wdata),
        .mem_fault  (mem_fault)
    );

    always #2 clk = ~clk;

    // strobes low, no memory opcode
    task automatic go_idle();
        ctx_save   = 1'b0;
        csr_enable = 1'b0;
        op         = 7'h00;
    endtask

    task automatic check_fault(input logic expected, input int line_no);
        checks++;
        assert (mem_fault === expected) else begin
            errors++;
            $display("[ERROR] %0t mem_fault: expected %0b, actual %0b (input line %0d)",
                     $time, expected, mem_fault, line_no);
        end
    endtask

    // drive one command, then check the fault one cycle later
    task automatic run_line(input string line, input int line_no);
        byte         cmd;
        int          n;
        int          want;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] exp;
        cmd  = line.getc(0);
        n    = 0;
        want = 0;
        f1   = '0;
        f2   = '0;
        f3   = '0;
        exp  = '0;
        case (cmd)
            "E": begin
                want   = 2;
                n      = $sscanf(line, "E %h %h", f1, exp);
                enable = f1[0];
            end
            "S": begin
                want     = 3;
                n        = $sscanf(line, "S %h %h %h", f1, f2, exp);
                id       = f1[7:0];
                sp       = f2[15:0];
                ctx_save = 1'b1;
            end
            "C": begin
                want       = 4;
                n          = $sscanf(line, "C %h %h %h %h", f1, f2, f3, exp);
                csr_addr   = f1[11:0];
                csr_op     = csr_op_e'(f2[1:0]);
                csr_wdata  = f3;
                csr_enable = 1'b1;
            end
            "A": begin
                want = 4;
                n    = $sscanf(line, "A %h %h %h %h", f1, f2, f3, exp);
                id   = f1[7:0];
                op   = f2[6:0];
                addr = f3[15:0];
            end
            default: begin
                errors++;
                $display("input line %0d has an unknown command and is skipped", line_no);
            end
        endcase
        if (want != 0) begin
            if (n != want) begin
                errors++;
                $display("input line %0d is missing fields", line_no);
            end
            @(negedge clk);
            check_fault(exp[0], line_no);
            go_idle();
        end
    endtask

    initial begin
        int    fd;
        int    tries;
        int    line_no;
        string line;
        errors     = 0;
        checks     = 0;
        clk        = 1'b0;
        reset      = 1'b1;
        enable     = 1'b0;
        addr       = '0;
        op         = 7'h00;
        id         = 8'h01;
        ctx_save   = 1'b0;
        sp         = '0;
        csr_enable = 1'b0;
        csr_addr   = '0;
        csr_op     = CSR_WRITE;
        csr_wdata  = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        fd    = 0;
        tries = 0;
        while (fd == 0 && tries < OPEN_TRIES) begin
            fd = $fopen("verif/pmp_input.txt", "r");
            tries++;
            if (fd == 0) begin
                @(negedge clk);
            end
        end

        if (fd == 0) begin
            errors++;
            $display("could not open verif/pmp_input.txt after %0d tries", OPEN_TRIES);
        end else begin
            line_no = 0;
            while (!$feof(fd) && line_no < MAX_LINES) begin
                line = "";
                line_no++;
                void'($fgets(line, fd));
                // blank lines and comments carry no command
                if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    run_line(line, line_no);
                end
            end
            if (!$feof(fd)) begin
                errors++;
                $display("input file did not end within %0d lines", MAX_LINES);
            end
            $fclose(fd);
        end

        if (checks == 0) begin
            errors++;
            $display("no command from the input file was checked");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verif/pmp_sva.sv */
module pmp_sva
    import pmp_access_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    enable,
    input opcode_t op,
    input logic    mem_fault
);

    timeunit 1ns;
    timeprecision 100ps;

    logic mem_op;

    assign mem_op = (op == OP_LOAD) || (op == OP_STORE);

    // fault register comes out of reset cleared
    reset_clears_fault: assert property (@(posedge clk) reset |=> !mem_fault)
        else $error("mem_fault high in the cycle after reset");

    disabled_no_fault: assert property (
        @(posedge clk) disable iff (reset) !enable |=> !mem_fault
    ) else $error("mem_fault after a cycle with enable low");

    // only loads and stores are checked
    other_op_no_fault: assert property (
        @(posedge clk) disable iff (reset) !mem_op |=> !mem_fault
    ) else $error("mem_fault after an opcode other than load or store");

endmodule

bind pmp pmp_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .op        (op),
    .mem_fault (mem_fault)
);

/* logic/pmp.sv */
module pmp
    import pmp_access_pkg::*;
    import pmp_csr_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         enable,      // unit on/off level
    input  mem_addr_t    addr,
    input  opcode_t      op,
    input  task_onehot_t id,

    input  logic         ctx_save,
    input  mem_addr_t    sp,

    input  logic         csr_enable,
    input  csr_addr_t    csr_addr,
    input  csr_op_e      csr_op,
    input  csr_word_t    csr_wdata,

    output logic         mem_fault    // to the interrupt controller
);

    task_idx_t cur_task;
    logic      task_valid;
    mem_addr_t stack_bound;

    mem_addr_t region_lo  [NUM_ROWS];
    mem_addr_t region_hi  [NUM_ROWS];
    pmp_cfg_t  region_cfg [NUM_ROWS];

    logic      hit   [NUM_ROWS];
    logic      grant [NUM_ROWS];

    pmp_task_tracker u_tracker (
        .clk         (clk),
        .reset       (reset),
        .id          (id),
        .ctx_save    (ctx_save),
        .sp          (sp),
        .cur_task    (cur_task),
        .task_valid  (task_valid),
        .stack_bound (stack_bound)
    );

    pmp_csr_file u_csr_file (
        .clk        (clk),
        .reset      (reset),
        .csr_enable (csr_enable),
        .csr_addr   (csr_addr),
        .csr_op     (csr_op),
        .csr_wdata  (csr_wdata),
        .cur_task   (cur_task),
        .region_lo  (region_lo),
        .region_hi  (region_hi),
        .region_cfg (region_cfg)
    );

    // one checker per region row of the current task
    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
        pmp_region_check u_check (
            .addr  (addr),
            .op    (op),
            .lo    (region_lo[r]),
            .hi    (region_hi[r]),
            .cfg   (region_cfg[r]),
            .hit   (hit[r]),
            .grant (grant[r])
        );
    end

    pmp_fault_resolve u_resolve (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .addr        (addr),
        .op          (op),
        .task_valid  (task_valid),
        .stack_bound (stack_bound),
        .hit         (hit),
        .grant       (grant),
        .mem_fault   (mem_fault)
    );

endmodule

/* logic/pmp_fault_resolve.sv */
module pmp_fault_resolve
    import pmp_access_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      enable,
    input  mem_addr_t addr,
    input  opcode_t   op,
    input  logic      task_valid,
    input  mem_addr_t stack_bound,

    input  logic      hit   [NUM_ROWS],
    input  logic      grant [NUM_ROWS],

    output logic      mem_fault
);

    logic is_mem_op;
    logic below_bound;
    logic granted;
    logic fault_d;

    assign is_mem_op   = (op == OP_LOAD) || (op == OP_STORE);
    assign below_bound = addr < stack_bound;

    // walk from the top so the lowest hitting row wins
    always_comb begin
        granted = 1'b0;  // no hit means no grant
        for (int r = NUM_ROWS - 1; r >= 0; r--) begin
            if (hit[r]) begin
                granted = grant[r];
            end
        end
    end

    assign fault_d = enable && is_mem_op && (!task_valid || (below_bound && !granted));

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_fault <= 1'b0;
        end else begin
            mem_fault <= fault_d;  // one cycle pulse per faulting access
        end
    end

endmodule

/* logic/pmp_region_check.sv */
module pmp_region_check
    import pmp_access_pkg::*;
(
    input  mem_addr_t addr,
    input  opcode_t   op,

    input  mem_addr_t lo,     // inclusive lower bound
    input  mem_addr_t hi,     // inclusive upper bound
    input  pmp_cfg_t  cfg,

    output logic      hit,
    output logic      grant
);

    // an empty region (lo > hi) never hits
    assign hit = (addr >= lo) && (addr <= hi);

    // permission bit that matches the access kind
    always_comb begin
        case (op)
            OP_LOAD:  grant = cfg[CFG_R];
            OP_STORE: grant = cfg[CFG_W];
            default:  grant = 1'b0;   // not a data access
        endcase
    end

endmodule

/* logic/pmp_csr_file.sv */
module pmp_csr_file
    import pmp_access_pkg::*;
    import pmp_csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      csr_enable,
    input  csr_addr_t csr_addr,
    input  csr_op_e   csr_op,
    input  csr_word_t csr_wdata,

    input  task_idx_t cur_task,
    output mem_addr_t region_lo  [NUM_ROWS],
    output mem_addr_t region_hi  [NUM_ROWS],
    output pmp_cfg_t  region_cfg [NUM_ROWS]
);

    localparam int NUM_ADDR_REGS = NUM_TASKS * NUM_ROWS;

    csr_word_t addr_regs [NUM_TASKS][NUM_ROWS];
    pmp_cfg_t  cfg_regs  [NUM_TASKS][NUM_ROWS];

    csr_addr_t addr_offs;
    csr_addr_t cfg_offs;
    logic      addr_sel;
    logic      cfg_sel;
    task_idx_t a_task;  // target of an address register access
    row_idx_t  a_row;
    task_idx_t c_task;  // target of a config register access

    csr_word_t old_addr;
    csr_word_t old_cfg;
    csr_word_t new_addr;
    csr_word_t new_cfg;

    // read-modify-write value for the three csr ops
    function automatic csr_word_t apply_op(csr_word_t old_val, csr_word_t data, csr_op_e op);
        case (op)
            CSR_SET:   return old_val | data;
            CSR_CLEAR: return old_val & ~data;
            default:   return data;
        endcase
    endfunction

    // address decode
    assign addr_offs = csr_addr - ADDR_CSR_BASE;
    assign cfg_offs  = csr_addr - CFG_CSR_BASE;
    assign addr_sel  = (csr_addr >= ADDR_CSR_BASE) && (addr_offs < NUM_ADDR_REGS);
    assign cfg_sel   = (csr_addr >= CFG_CSR_BASE) && (cfg_offs < NUM_TASKS);

    assign {a_task, a_row} = addr_offs[4:0]; // task * NUM_ROWS + row
    assign c_task          = cfg_offs[2:0];

    assign old_addr = addr_regs[a_task][a_row];

    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            old_cfg[8*r +: 8] = cfg_regs[c_task][r];
        end
    end

    assign new_addr = apply_op(old_addr, csr_wdata, csr_op);
    assign new_cfg  = apply_op(old_cfg, csr_wdata, csr_op);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_TASKS; t++) begin
                for (int r = 0; r < NUM_ROWS; r++) begin
                    addr_regs[t][r] <= '0;
                    cfg_regs[t][r]  <= '0;
                end
            end
        end else if (csr_enable) begin
            // a locked row keeps its bounds
            if (addr_sel && !cfg_regs[a_task][a_row][CFG_L]) begin
                addr_regs[a_task][a_row] <= new_addr;
            end
            if (cfg_sel) begin
                for (int r = 0; r < NUM_ROWS; r++) begin
                    if (!cfg_regs[c_task][r][CFG_L]) begin
                        cfg_regs[c_task][r] <= new_cfg[8*r +: 8];
                    end
                end
            end
        end
    end

    // current task's view of the table
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            region_lo[r]  = addr_regs[cur_task][r][15:0];
            region_hi[r]  = addr_regs[cur_task][r][31:16];
            region_cfg[r] = cfg_regs[cur_task][r];
        end
    end

endmodule

/* logic/pmp_task_tracker.sv */
module pmp_task_tracker
    import pmp_access_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  task_onehot_t id,          // one-hot running task
    input  logic         ctx_save,    // save strobe from the core
    input  mem_addr_t    sp,

    output task_idx_t    cur_task,
    output logic         task_valid,
    output mem_addr_t    stack_bound
);

    mem_addr_t bounds [NUM_TASKS];  // saved stack bound per task

    // one-hot to index
    // only meaningful when task_valid is high
    always_comb begin
        cur_task = '0;
        for (int t = 0; t < NUM_TASKS; t++) begin
            if (id[t]) begin
                cur_task = cur_task | task_idx_t'(t);
            end
        end
    end

    assign task_valid = $onehot(id);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_TASKS; t++) begin
                bounds[t] <= '0;  // bound 0 lets everything through
            end
        end else if (ctx_save && task_valid) begin
            bounds[cur_task] <= sp;
        end
    end

    assign stack_bound = bounds[cur_task];

endmodule

/* logic/pmp_csr_pkg.sv */
package pmp_csr_pkg;

    // csr address space of the core
    typedef logic [11:0] csr_addr_t;

    // write data as seen by the csr port
    typedef logic [31:0] csr_word_t;

    // same encoding as funct3 of csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    // region address registers, one per task and row
    // word layout is {upper bound, lower bound}, both inclusive
    localparam csr_addr_t ADDR_CSR_BASE = 12'h400;

    // config registers, one per task, byte n belongs to row n
    localparam csr_addr_t CFG_CSR_BASE = 12'h480;

endpackage

/* logic/pmp_access_pkg.sv */
package pmp_access_pkg;

    // data side address, also used for the saved stack bound
    typedef logic [15:0] mem_addr_t;

    // major opcode field of the instruction
    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    // task and region counts
    localparam int NUM_TASKS = 8;
    localparam int NUM_ROWS  = 4;

    typedef logic [NUM_TASKS-1:0] task_onehot_t; // one bit per task
    typedef logic [2:0]           task_idx_t;
    typedef logic [1:0]           row_idx_t;

    // per region config byte
    typedef logic [7:0] pmp_cfg_t;

    // bit positions inside pmp_cfg_t
    localparam int CFG_R = 0; // read allowed
    localparam int CFG_W = 1; // write allowed
    localparam int CFG_X = 2; // execute, kept but not checked
    localparam int CFG_L = 7; // row locked until reset

endpackage
